// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = ooo_wrf_channel_tb
FILELIST = ooo_wrf_channel.f
OBJ_DIR  = obj_dir

BIN      = $(OBJ_DIR)/V$(TOP)
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SOURCES)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'RESULT: PASS'

clean:
	rm -rf $(OBJ_DIR)

// File: bench/clock_gen.sv
// Testbench clock and reset
`timescale 1ns/100ps

module clock_gen #(
   parameter int RST_CYCLES = 16
) (
   output logic clk_o,
   output logic rst_o
);

   // 20 ns period
   initial begin
      clk_o = 1'b0;
      forever #10 clk_o = ~clk_o;
   end

   // Reset drops just after the last reset edge
   initial begin
      rst_o = 1'b1;
      repeat (RST_CYCLES) @(posedge clk_o);
      #2 rst_o = 1'b0;
   end

endmodule

// File: bench/ooo_wrf_channel_tb.sv
// Out-of-order write channel testbench
`timescale 1ns/100ps

module ooo_wrf_channel_tb
   import wrf_pkg::*;
;

   // Minimum delay per kind
   localparam int M_MIN = 4;
   localparam int I_MIN = 8;
   // Longest run is well under 1500 cycles
   localparam int MAX_CYCLES = 4000;
   // A full channel with a few fences empties in far fewer cycles
   localparam int DRAIN_LIMIT = 600;
   localparam int N_MIXED    = 240;
   // Read side modes
   localparam int RD_HOLD = 0;
   localparam int RD_ALL  = 1;
   localparam int RD_RAND = 2;

   // Outstanding write as seen on the input
   typedef struct {
      wr_kind_t           kind;
      logic [ADDR_W-1:0]  addr;
      logic [DATA_W-1:0]  data;
      int                 epoch;
      int                 cycle;
   } entry_t;

   logic               clk;
   logic               rst;
   wr_kind_t           wr_kind_i;
   logic [ADDR_W-1:0]  addr_i;
   logic [DATA_W-1:0]  data_i;
   logic               write_en_i;
   logic               full_o;
   wr_kind_t           kind_o;
   logic [ADDR_W-1:0]  addr_o;
   logic [DATA_W-1:0]  data_o;
   logic               valid_o;
   logic               read_en_i;
   logic               empty_o;

   // Scoreboard
   entry_t      pending[$];
   // Fence address and data, never to come out
   logic [ADDR_W+DATA_W-1:0] fences[$];
   int          epoch     = 0;
   int          cycle_cnt = 0;
   int          errors    = 0;
   int          n_writes  = 0;
   int          n_fences  = 0;
   int          match_idx = -1;
   int          rd_mode   = RD_HOLD;
   logic [31:0] lcg_state = 32'h8b1a;

   // Lookup results for the head entry
   logic out_found = 1'b1;
   logic not_fence = 1'b1;
   logic epoch_ok  = 1'b1;
   logic delay_ok  = 1'b1;
   logic idle_chk;
   logic saw_full;

   clock_gen u_clock_gen (
      .clk_o (clk),
      .rst_o (rst)
   );

   ooo_wrf_channel dut (
      .clk        (clk),
      .rst        (rst),
      .wr_kind_i  (wr_kind_i),
      .addr_i     (addr_i),
      .data_i     (data_i),
      .write_en_i (write_en_i),
      .full_o     (full_o),
      .kind_o     (kind_o),
      .addr_o     (addr_o),
      .data_o     (data_o),
      .valid_o    (valid_o),
      .read_en_i  (read_en_i),
      .empty_o    (empty_o)
   );

   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic int min_delay(input wr_kind_t kind);
      return (kind == WRLINE_I) ? I_MIN : M_MIN;
   endfunction

   task automatic flag_error(input string msg);
      errors++;
      $display("** Error @ %0t: %s", $time, msg);
   endtask

   // Record writes and retire popped entries
   always @(posedge clk) begin : bookkeeping
      entry_t e;
      cycle_cnt = cycle_cnt + 1;
      if (!rst) begin
         if (valid_o && read_en_i && (match_idx >= 0)) begin
            pending.delete(match_idx);
         end
         if (write_en_i) begin
            // A fence closes the current epoch
            if (wr_kind_i == WRFENCE) begin
               epoch = epoch + 1;
               n_fences++;
               fences.push_back({addr_i, data_i});
            end else begin
               e.kind  = wr_kind_i;
               e.addr  = addr_i;
               e.data  = data_i;
               e.epoch = epoch;
               e.cycle = cycle_cnt;
               pending.push_back(e);
               n_writes++;
            end
         end
      end
   end

   // Match the head entry while everything is stable
   always @(negedge clk) begin : lookup
      int oldest;
      int idx;
      oldest = epoch;
      idx    = -1;
      foreach (pending[i]) begin
         if (pending[i].epoch < oldest) begin
            oldest = pending[i].epoch;
         end
         if ((idx < 0) && (pending[i].kind == kind_o) && (pending[i].addr == addr_o)
             && (pending[i].data == data_o)) begin
            idx = i;
         end
      end
      not_fence = 1'b1;
      foreach (fences[j]) begin
         if (fences[j] == {addr_o, data_o}) begin
            not_fence = 1'b0;
         end
      end
      match_idx = idx;
      out_found = (idx >= 0);
      epoch_ok  = 1'b0;
      delay_ok  = 1'b0;
      if (idx >= 0) begin
         epoch_ok = (pending[idx].epoch == oldest);
         delay_ok = ((cycle_cnt - pending[idx].cycle) >= min_delay(kind_o));
      end
   end

   // Watchdog
   always @(negedge clk) begin : watchdog
      if (cycle_cnt >= MAX_CYCLES) begin
         $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
         $display("RESULT: FAIL");
         $finish;
      end
   end

   a_known: assert property (@(posedge clk) disable iff (rst) valid_o |-> out_found)
      else flag_error("output matches no outstanding write");
   a_no_fence: assert property (@(posedge clk) disable iff (rst) valid_o |-> not_fence)
      else flag_error("fence reached the output");
   a_epoch: assert property (@(posedge clk) disable iff (rst) valid_o |-> epoch_ok)
      else flag_error("output passed a fence ahead of older writes");
   a_delay: assert property (@(posedge clk) disable iff (rst) valid_o |-> delay_ok)
      else flag_error("output earlier than its minimum delay");
   a_idle: assert property (@(posedge clk) disable iff (rst)
         idle_chk |-> (empty_o && !valid_o && !full_o))
      else flag_error("status flags not idle");

   // One cycle, inputs change 2 ns after the edge
   task automatic step();
      logic [31:0] r;
      @(posedge clk);
      #2;
      r = next_rand();
      case (rd_mode)
         RD_HOLD: read_en_i = 1'b0;
         RD_ALL:  read_en_i = 1'b1;
         default: read_en_i = (r[1:0] != 2'b00);
      endcase
   endtask

   // Single-cycle write strobe, never while full_o
   task automatic send(input wr_kind_t kind);
      logic [31:0] r;
      while (full_o) begin
         step();
      end
      r          = next_rand();
      wr_kind_i  = kind;
      addr_i     = r[31:16];
      data_i     = next_rand();
      write_en_i = 1'b1;
      step();
      write_en_i = 1'b0;
   endtask

   task automatic send_random_write();
      logic [31:0] r;
      r = next_rand();
      send(r[20] ? WRLINE_I : WRLINE_M);
   endtask

   // Read until every write is out, then check status
   task automatic drain();
      int waited;
      waited  = 0;
      rd_mode = RD_ALL;
      while (((pending.size() != 0) || valid_o) && (waited < DRAIN_LIMIT)) begin
         step();
         waited++;
      end
      if (pending.size() != 0) begin
         errors++;
         $display("%0d writes were never delivered", pending.size());
      end
      idle_chk = 1'b1;
      step();
      idle_chk = 1'b0;
   endtask

   initial begin
      logic [31:0] r;
      wr_kind_i  = WRLINE_M;
      addr_i     = '0;
      data_i     = '0;
      write_en_i = 1'b0;
      read_en_i  = 1'b0;
      idle_chk   = 1'b0;
      saw_full   = 1'b0;
      wait (!rst);
      step();
      idle_chk = 1'b1;
      step();
      idle_chk = 1'b0;

      // Mixed writes and fences, random reads
      rd_mode = RD_RAND;
      for (int i = 0; i < N_MIXED; i++) begin
         r = next_rand();
         if (r[7:0] < 8'd14) begin
            send(WRFENCE);
         end else begin
            send_random_write();
         end
         if (r[11:9] == 3'd0) begin
            step();
         end
      end
      drain();

      // Reads held off until the input side reports full
      rd_mode = RD_HOLD;
      step();
      for (int i = 0; (i < 64) && !full_o; i++) begin
         send_random_write();
      end
      saw_full = full_o;
      assert (saw_full) else begin
         errors++;
         $display("full_o never rose while reads were held off");
      end
      repeat (20) step();
      drain();

      // Dense fences
      rd_mode = RD_RAND;
      for (int i = 0; i < 40; i++) begin
         if ((i % 3) == 2) begin
            send(WRFENCE);
         end else begin
            send_random_write();
         end
      end
      drain();

      $display("Done: %0d errors, %0d writes, %0d fences", errors, n_writes, n_fences);
      if (errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

// File: ooo_wrf_channel.f
source/wrf_pkg.sv
source/latency_pkg.sv
source/req_fifo.sv
source/fence_gate.sv
source/delay_config.sv
source/latency_buffer.sv
source/ooo_wrf_channel.sv
bench/clock_gen.sv
bench/ooo_wrf_channel_tb.sv

// File: source/delay_config.sv
// Per-kind delay from an LFSR
`timescale 1ns/100ps

module delay_config
   import wrf_pkg::*;
   import latency_pkg::*;
(
   input  logic              clk,
   input  logic              rst,
   input  logic              push_i,
   input  wr_kind_t          kind_i,
   output logic [DLY_W-1:0]  delay_o
);

   localparam int SPAN_W = $clog2(DLY_SPAN);

   logic [15:0]      lfsr;
   logic             feedback;
   logic [DLY_W-1:0] min_dly;

   // XOR of tapped bits
   assign feedback = ^(lfsr & LFSR_TAPS);

   // Step once per accepted push
   always_ff @(posedge clk) begin
      if (rst) begin
         lfsr <= LFSR_SEED;
      end else if (push_i) begin
         lfsr <= {lfsr[14:0], feedback};
      end
   end

   // Range table, fences never pushed
   always_comb begin
      case (kind_i)
         WRLINE_M: min_dly = DLY_W'(WRLINE_M_MIN);
         WRLINE_I: min_dly = DLY_W'(WRLINE_I_MIN);
         default:  min_dly = DLY_W'(WRLINE_M_MIN);
      endcase
   end

   // Low bits give value modulo the span
   assign delay_o = min_dly + DLY_W'(lfsr[SPAN_W-1:0]);

endmodule

// File: source/fence_gate.sv
// Write fence trap between input FIFO and latency buffer
`timescale 1ns/100ps

module fence_gate
   import wrf_pkg::*;
(
   input  logic      clk,
   input  logic      rst,
   input  wr_req_t   head_i,
   input  logic      head_valid_i,
   output logic      pop_o,
   input  logic      has_space_i,
   input  logic      drained_i,
   input  logic      out_empty_i,
   output logic      push_o,
   output wr_out_t   push_req_o,
   output wr_kind_t  push_kind_o
);

   typedef enum logic [1:0] {
      PASS       = 2'd0,
      WAIT_DRAIN = 2'd1,
      RELEASE    = 2'd2
   } gate_state_t;

   gate_state_t state;
   logic        is_fence;

   assign is_fence = head_valid_i && (head_i.kind == WRFENCE);

   // Writes go straight through when a station is free
   assign push_o = (state == PASS) && head_valid_i && !is_fence && has_space_i;
   // Fence leaves the FIFO only in RELEASE, nothing pushed
   assign pop_o  = push_o || (state == RELEASE);

   // Kind collapsed to the M/I flag
   assign push_req_o.inv  = (head_i.kind == WRLINE_I);
   assign push_req_o.addr = head_i.addr;
   assign push_req_o.data = head_i.data;
   assign push_kind_o     = head_i.kind;

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= PASS;
      end else begin
         case (state)
            PASS: begin
               if (is_fence) begin
                  state <= WAIT_DRAIN;
               end
            end
            // Hold until every earlier write has left the channel
            WAIT_DRAIN: begin
               if (drained_i && out_empty_i) begin
                  state <= RELEASE;
               end
            end
            RELEASE: state <= PASS;
            default: state <= PASS;
         endcase
      end
   end

endmodule

// File: source/latency_buffer.sv
// Wait stations with per-entry countdown
`timescale 1ns/100ps

module latency_buffer
   import wrf_pkg::*;
   import latency_pkg::*;
#(
   parameter int NUM_STATIONS = 8
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              push_i,
   input  wr_out_t           push_req_i,
   input  logic [DLY_W-1:0]  delay_i,
   output logic              has_space_o,
   output logic              drained_o,
   input  logic              out_alm_full_i,
   output logic              out_wen_o,
   output wr_out_t           out_data_o
);

   localparam int IDX_W = $clog2(NUM_STATIONS);

   // Station arrays
   slot_state_t      state   [NUM_STATIONS];
   logic [DLY_W-1:0] cnt     [NUM_STATIONS];
   wr_out_t          payload [NUM_STATIONS];

   logic [NUM_STATIONS-1:0] free_vec;
   logic [NUM_STATIONS-1:0] ready_vec;
   logic [IDX_W:0]          busy_cnt;

   // Registered search results
   logic [IDX_W-1:0] push_slot;
   logic             push_ok;
   logic [IDX_W-1:0] pop_slot;
   logic             pop_ok;
   logic [IDX_W-1:0] nxt_push;
   logic             nxt_push_ok;
   logic [IDX_W-1:0] nxt_pop;
   logic             nxt_pop_ok;
   logic             pop_fire;

   // Hide the slot in use this cycle from the next search
   always_comb begin
      for (int i = 0; i < NUM_STATIONS; i++) begin
         free_vec[i]  = (state[i] == IDLE) && !(push_i && (push_slot == IDX_W'(i)));
         ready_vec[i] = (state[i] == READY) && !(pop_fire && (pop_slot == IDX_W'(i)));
      end
   end

   always_comb begin
      busy_cnt = '0;
      for (int i = 0; i < NUM_STATIONS; i++) begin
         busy_cnt = busy_cnt + (IDX_W + 1)'(state[i] != IDLE);
      end
   end

   // Round-robin from the last choice, nearest candidate wins
   always_comb begin
      logic [IDX_W-1:0] idx;
      nxt_push    = push_slot;
      nxt_push_ok = 1'b0;
      nxt_pop     = pop_slot;
      nxt_pop_ok  = 1'b0;
      for (int k = NUM_STATIONS; k >= 1; k--) begin
         idx = IDX_W'((int'(push_slot) + k) % NUM_STATIONS);
         if (free_vec[idx]) begin
            nxt_push    = idx;
            nxt_push_ok = 1'b1;
         end
         idx = IDX_W'((int'(pop_slot) + k) % NUM_STATIONS);
         if (ready_vec[idx]) begin
            nxt_pop    = idx;
            nxt_pop_ok = 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         push_slot <= '0;
         push_ok   <= 1'b0;
         pop_slot  <= '0;
         pop_ok    <= 1'b0;
      end else begin
         push_slot <= nxt_push;
         push_ok   <= nxt_push_ok;
         pop_slot  <= nxt_pop;
         pop_ok    <= nxt_pop_ok;
      end
   end

   // One release per cycle, held off by output back-pressure
   assign pop_fire = pop_ok && !out_alm_full_i;

   for (genvar g = 0; g < NUM_STATIONS; g++) begin : g_station
      logic load;
      logic leave;

      assign load  = push_i && (push_slot == IDX_W'(g));
      assign leave = pop_fire && (pop_slot == IDX_W'(g));

      always_ff @(posedge clk) begin
         if (rst) begin
            state[g] <= IDLE;
         end else begin
            case (state[g])
               IDLE:      if (load) state[g] <= COUNTDOWN;
               COUNTDOWN: if (cnt[g] == '0) state[g] <= READY;
               READY:     if (leave) state[g] <= IDLE;
               default:   state[g] <= IDLE;
            endcase
         end
      end

      // Countdown and payload
      always_ff @(posedge clk) begin
         if (load) begin
            cnt[g]     <= delay_i;
            payload[g] <= push_req_i;
         end else if ((state[g] == COUNTDOWN) && (cnt[g] != '0)) begin
            cnt[g] <= cnt[g] - 1'b1;
         end
      end
   end

   // Output stage into the output FIFO
   always_ff @(posedge clk) begin
      if (rst) begin
         out_wen_o <= 1'b0;
      end else begin
         out_wen_o <= pop_fire;
      end
   end

   always_ff @(posedge clk) begin
      if (pop_fire) begin
         out_data_o <= payload[pop_slot];
      end
   end

   // Keep one station spare, and only with a valid slot in hand
   assign has_space_o = (busy_cnt < (IDX_W + 1)'(NUM_STATIONS - 1)) && push_ok;
   // Staged entry still counts as inside
   assign drained_o   = (busy_cnt == '0) && !out_wen_o;

endmodule

// File: source/latency_pkg.sv
// Latency model constants
package latency_pkg;

   // Countdown width per station
   localparam int DLY_W = 8;

   // Minimum delay per kind, random part spans DLY_SPAN values
   localparam int WRLINE_M_MIN = 4;
   localparam int WRLINE_I_MIN = 8;
   localparam int DLY_SPAN     = 16;

   // 16-bit Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1
   localparam logic [15:0] LFSR_SEED = 16'hace1;
   localparam logic [15:0] LFSR_TAPS = 16'hb400;

   // Wait station state
   typedef enum logic [1:0] {
      IDLE      = 2'd0,
      COUNTDOWN = 2'd1,
      READY     = 2'd2
   } slot_state_t;

endpackage

// File: source/ooo_wrf_channel.sv
// Out-of-order write channel with fence
`timescale 1ns/100ps

module ooo_wrf_channel
   import wrf_pkg::*;
   import latency_pkg::*;
#(
   parameter int NUM_STATIONS    = 8,
   parameter int IN_DEPTH_LOG2   = 3,
   parameter int IN_FULL_THRESH  = 5,
   parameter int OUT_DEPTH_LOG2  = 3,
   parameter int OUT_FULL_THRESH = 6
) (
   input  logic               clk,
   input  logic               rst,
   // Request side
   input  wr_kind_t           wr_kind_i,
   input  logic [ADDR_W-1:0]  addr_i,
   input  logic [DATA_W-1:0]  data_i,
   input  logic               write_en_i,
   output logic               full_o,
   // Release side
   output wr_kind_t           kind_o,
   output logic [ADDR_W-1:0]  addr_o,
   output logic [DATA_W-1:0]  data_o,
   output logic               valid_o,
   input  logic               read_en_i,
   output logic               empty_o
);

   wr_req_t   in_req;
   wr_req_t   head;
   logic      head_valid;
   logic      head_pop;
   logic      push;
   wr_out_t   push_req;
   wr_kind_t  push_kind;
   logic [DLY_W-1:0] delay;
   logic      has_space;
   logic      drained;
   logic      out_alm_full;
   logic      out_wen;
   wr_out_t   out_din;
   wr_out_t   out_head;

   assign in_req = '{kind: wr_kind_i, addr: addr_i, data: data_i};

   req_fifo #(
      .payload_t   (wr_req_t),
      .DEPTH_LOG2  (IN_DEPTH_LOG2),
      .FULL_THRESH (IN_FULL_THRESH)
   ) u_in_fifo (
      .clk        (clk),
      .rst        (rst),
      .wr_en_i    (write_en_i),
      .data_i     (in_req),
      .rd_en_i    (head_pop),
      .data_o     (head),
      .valid_o    (head_valid),
      .empty_o    (),
      .alm_full_o (full_o)
   );

   fence_gate u_fence_gate (
      .clk          (clk),
      .rst          (rst),
      .head_i       (head),
      .head_valid_i (head_valid),
      .pop_o        (head_pop),
      .has_space_i  (has_space),
      .drained_i    (drained),
      .out_empty_i  (empty_o),
      .push_o       (push),
      .push_req_o   (push_req),
      .push_kind_o  (push_kind)
   );

   delay_config u_delay_config (
      .clk     (clk),
      .rst     (rst),
      .push_i  (push),
      .kind_i  (push_kind),
      .delay_o (delay)
   );

   latency_buffer #(
      .NUM_STATIONS (NUM_STATIONS)
   ) u_latency_buffer (
      .clk            (clk),
      .rst            (rst),
      .push_i         (push),
      .push_req_i     (push_req),
      .delay_i        (delay),
      .has_space_o    (has_space),
      .drained_o      (drained),
      .out_alm_full_i (out_alm_full),
      .out_wen_o      (out_wen),
      .out_data_o     (out_din)
   );

   req_fifo #(
      .payload_t   (wr_out_t),
      .DEPTH_LOG2  (OUT_DEPTH_LOG2),
      .FULL_THRESH (OUT_FULL_THRESH)
   ) u_out_fifo (
      .clk        (clk),
      .rst        (rst),
      .wr_en_i    (out_wen),
      .data_i     (out_din),
      .rd_en_i    (read_en_i),
      .data_o     (out_head),
      .valid_o    (valid_o),
      .empty_o    (empty_o),
      .alm_full_o (out_alm_full)
   );

   // WRLINE_M and WRLINE_I differ only in bit 0
   assign kind_o = wr_kind_t'({1'b0, out_head.inv});
   assign addr_o = out_head.addr;
   assign data_o = out_head.data;

endmodule

// File: source/req_fifo.sv
// Show-ahead synchronous FIFO
`timescale 1ns/100ps

module req_fifo #(
   parameter type payload_t   = logic,
   parameter int  DEPTH_LOG2  = 3,
   parameter int  FULL_THRESH = 5,
   parameter int  CNT_W       = DEPTH_LOG2 + 1
) (
   input  logic      clk,
   input  logic      rst,
   input  logic      wr_en_i,
   input  payload_t  data_i,
   input  logic      rd_en_i,
   output payload_t  data_o,
   output logic      valid_o,
   output logic      empty_o,
   output logic      alm_full_o
);

   localparam int DEPTH = 1 << DEPTH_LOG2;

   // Storage, no reset needed
   payload_t mem [DEPTH];

   logic [DEPTH_LOG2-1:0] wr_ptr;
   logic [DEPTH_LOG2-1:0] rd_ptr;
   logic [CNT_W-1:0]      count;
   logic                  do_wr;
   logic                  do_rd;

   // Pop only a valid head
   assign do_rd = rd_en_i && !empty_o;
   // Drop writes at true capacity unless a pop frees a slot
   assign do_wr = wr_en_i && ((count < CNT_W'(DEPTH)) || do_rd);

   always_ff @(posedge clk) begin
      if (do_wr) begin
         mem[wr_ptr] <= data_i;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // Net occupancy change
         if (do_wr && !do_rd) begin
            count <= count + 1'b1;
         end else if (do_rd && !do_wr) begin
            count <= count - 1'b1;
         end
      end
   end

   // Head always visible
   assign data_o     = mem[rd_ptr];
   assign empty_o    = (count == '0);
   assign valid_o    = !empty_o;
   assign alm_full_o = (count >= CNT_W'(FULL_THRESH));

endmodule

// File: source/wrf_pkg.sv
// Write channel request types
package wrf_pkg;

   // Field widths
   localparam int ADDR_W = 16;
   localparam int DATA_W = 32;

   // Request kinds as seen on the input
   typedef enum logic [1:0] {
      WRLINE_M = 2'd0,
      WRLINE_I = 2'd1,
      WRFENCE  = 2'd2
   } wr_kind_t;

   // Input FIFO entry, fences included
   typedef struct packed {
      wr_kind_t            kind;
      logic [ADDR_W-1:0]   addr;
      logic [DATA_W-1:0]   data;
   } wr_req_t;

   // Entry past the fence gate
   // inv set for WRLINE_I, clear for WRLINE_M
   typedef struct packed {
      logic                inv;
      logic [ADDR_W-1:0]   addr;
      logic [DATA_W-1:0]   data;
   } wr_out_t;

endpackage
